// File: cnn_settings.svh
`ifndef CNN_SETTINGS_SVH
`define CNN_SETTINGS_SVH

// input channels per tile and per kernel set
`define CNN_CHANNELS 8

// tile edge in pixels
`define CNN_TILE 4

// kernel edge in weights
`define CNN_KERNEL 3

// tiles before a new kernel set is expected
`define CNN_TILES_PER_SET 2

// lowest bit of the pooled max that lands in the output byte
`define CNN_OUT_SHIFT 7

`endif

// File: cnn_pkg.sv
`default_nettype none

`include "cnn_settings.svh"

package cnn_pkg;

    typedef logic signed [7:0]  pixel_t;   // pixel or weight
    typedef logic signed [22:0] acc_t;     // full conv sum over 8 channels
    typedef logic        [2:0]  chan_t;

    // flat stores, channel major then row then column
    typedef pixel_t [`CNN_CHANNELS*`CNN_KERNEL*`CNN_KERNEL-1:0] kern_arr_t;
    typedef pixel_t [`CNN_CHANNELS*`CNN_TILE*`CNN_TILE-1:0]     tile_arr_t;

    typedef struct packed {
        logic       en;
        chan_t      ch;
        logic [3:0] idx;    // row*3 + col
    } kern_wr_t;

    // one beat fills rows 2*pair and 2*pair+1 of column col
    typedef struct packed {
        logic       en;
        chan_t      ch;
        logic       pair;
        logic [1:0] col;
    } tile_wr_t;

    typedef struct packed {
        logic ox;
        logic oy;
        logic first;
        logic last;
    } win_pos_t;

    typedef enum logic [1:0] {
        ST_KERNEL,
        ST_TILE,
        ST_CONV
    } load_state_t;

endpackage

`default_nettype wire

// File: load_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_settings.svh"

module load_ctrl
    import cnn_pkg::*;
(
    input  wire logic i_clk,
    input  wire logic i_rst,
    input  wire logic i_valid,
    output kern_wr_t  o_kern_wr,
    output tile_wr_t  o_tile_wr,
    output win_pos_t  o_pos,
    output logic      o_conv
);

    localparam int KBEATS = `CNN_KERNEL * `CNN_KERNEL;
    localparam int TBEATS = `CNN_TILE * `CNN_TILE / 2;    // two pixels per beat
    localparam int TCW    = $clog2(`CNN_TILES_PER_SET) + 1;

    load_state_t    state;
    logic [3:0]     beat_cnt;
    chan_t          ch_cnt;
    logic [TCW-1:0] tile_cnt;
    logic [1:0]     pos_cnt;    // bit 0 is ox, bit 1 is oy
    logic           last_ch;

    assign last_ch = (ch_cnt == chan_t'(`CNN_CHANNELS - 1));

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
        begin
            state    <= ST_KERNEL;
            beat_cnt <= '0;
            ch_cnt   <= '0;
            tile_cnt <= '0;
            pos_cnt  <= '0;
        end
        else
        begin
            case (state)
                ST_KERNEL:
                begin
                    if (i_valid)
                    begin
                        if (beat_cnt == 4'(KBEATS - 1))
                        begin
                            beat_cnt <= '0;
                            ch_cnt   <= last_ch ? '0 : ch_cnt + 1'b1;
                            if (last_ch)
                            begin
                                state <= ST_TILE;
                            end
                        end
                        else
                        begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                ST_TILE:
                begin
                    if (i_valid)
                    begin
                        if (beat_cnt == 4'(TBEATS - 1))
                        begin
                            beat_cnt <= '0;
                            ch_cnt   <= last_ch ? '0 : ch_cnt + 1'b1;
                            if (last_ch)
                            begin
                                state   <= ST_CONV;
                                pos_cnt <= '0;
                            end
                        end
                        else
                        begin
                            beat_cnt <= beat_cnt + 1'b1;
                        end
                    end
                end
                ST_CONV:
                begin
                    // i_valid ignored here
                    pos_cnt <= pos_cnt + 1'b1;
                    if (pos_cnt == 2'd3)
                    begin
                        if (tile_cnt == TCW'(`CNN_TILES_PER_SET - 1))
                        begin
                            tile_cnt <= '0;
                            state    <= ST_KERNEL;
                        end
                        else
                        begin
                            tile_cnt <= tile_cnt + 1'b1;
                            state    <= ST_TILE;
                        end
                    end
                end
                default:
                begin
                    state <= ST_KERNEL;
                end
            endcase
        end
    end

    assign o_kern_wr = '{
        en:  (state == ST_KERNEL) && i_valid,
        ch:  ch_cnt,
        idx: beat_cnt
    };

    assign o_tile_wr = '{
        en:   (state == ST_TILE) && i_valid,
        ch:   ch_cnt,
        pair: beat_cnt[2],      // beat / 4
        col:  beat_cnt[1:0]     // beat % 4
    };

    assign o_pos = '{
        ox:    pos_cnt[0],
        oy:    pos_cnt[1],
        first: pos_cnt == 2'd0,
        last:  pos_cnt == 2'd3
    };

    assign o_conv = (state == ST_CONV);

endmodule

`default_nettype wire

// File: kernel_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_settings.svh"

module kernel_buffer
    import cnn_pkg::*;
(
    input  wire logic     i_clk,
    input  wire logic     i_rst,
    input  wire kern_wr_t i_wr,
    input  wire pixel_t   i_data,
    output kern_arr_t     o_kernels
);

    localparam int KSZ = `CNN_KERNEL * `CNN_KERNEL;

    kern_arr_t kern_q;
    int        waddr;

    assign waddr = int'(i_wr.ch) * KSZ + int'(i_wr.idx);

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
        begin
            kern_q <= '0;
        end
        else if (i_wr.en)
        begin
            kern_q[waddr] <= i_data;    // one weight per beat
        end
    end

    assign o_kernels = kern_q;

endmodule

`default_nettype wire

// File: tile_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_settings.svh"

module tile_buffer
    import cnn_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_rst,
    input  wire tile_wr_t    i_wr,
    input  wire logic [15:0] i_data,
    output tile_arr_t        o_tile
);

    localparam int TSZ = `CNN_TILE * `CNN_TILE;

    tile_arr_t tile_q;
    int        waddr;

    // even row of the pair, same column
    assign waddr = int'(i_wr.ch) * TSZ
                 + int'(i_wr.pair) * 2 * `CNN_TILE
                 + int'(i_wr.col);

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
        begin
            tile_q <= '0;
        end
        else if (i_wr.en)
        begin
            tile_q[waddr]             <= pixel_t'(i_data[15:8]);
            tile_q[waddr + `CNN_TILE] <= pixel_t'(i_data[7:0]);   // row below
        end
    end

    assign o_tile = tile_q;

endmodule

`default_nettype wire

// File: pe_dot.sv
`timescale 1ns/100ps
`default_nettype none

module pe_dot
    import cnn_pkg::*;
#(
    parameter int TERMS = 18
)
(
    input  wire pixel_t [TERMS-1:0] i_window,
    input  wire pixel_t [TERMS-1:0] i_weights,
    output acc_t                    o_sum
);

    acc_t sum;

    // 8x8 signed products, summed at accumulator width
    always_comb
    begin
        sum = '0;
        for (int k = 0; k < TERMS; k++)
        begin
            sum = sum + acc_t'(i_window[k]) * acc_t'(i_weights[k]);
        end
    end

    assign o_sum = sum;

endmodule

`default_nettype wire

// File: conv_pool.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_settings.svh"

module conv_pool
    import cnn_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_rst,
    input  wire kern_arr_t i_kernels,
    input  wire tile_arr_t i_tile,
    input  wire win_pos_t  i_pos,
    input  wire logic      i_conv,
    output logic [7:0]     o_data,
    output logic           o_valid
);

    localparam int KSZ = `CNN_KERNEL * `CNN_KERNEL;
    localparam int TSZ = `CNN_TILE * `CNN_TILE;
    localparam int NPE = `CNN_CHANNELS / 2;    // one PE per channel pair

    pixel_t [NPE-1:0][2*KSZ-1:0] pe_win;
    pixel_t [NPE-1:0][2*KSZ-1:0] pe_wgt;
    acc_t   [NPE-1:0]            pe_sum;
    acc_t                        conv_sum;
    acc_t                        max_base;
    acc_t                        max_next;
    acc_t                        max_q;

    // 3x3 window at (ox, oy), row offset from oy
    always_comb
    begin
        for (int c = 0; c < `CNN_CHANNELS; c++)
        begin
            for (int r = 0; r < `CNN_KERNEL; r++)
            begin
                for (int k = 0; k < `CNN_KERNEL; k++)
                begin
                    pe_win[c/2][(c%2)*KSZ + r*`CNN_KERNEL + k] =
                        i_tile[c*TSZ + (r + int'(i_pos.oy))*`CNN_TILE + k + int'(i_pos.ox)];
                    pe_wgt[c/2][(c%2)*KSZ + r*`CNN_KERNEL + k] =
                        i_kernels[c*KSZ + r*`CNN_KERNEL + k];
                end
            end
        end
    end

    for (genvar p = 0; p < NPE; p++)
    begin : g_pe
        pe_dot #(
            .TERMS     (2 * KSZ)
        ) u_pe (
            .i_window  (pe_win[p]),
            .i_weights (pe_wgt[p]),
            .o_sum     (pe_sum[p])
        );
    end

    always_comb
    begin
        conv_sum = '0;
        for (int p = 0; p < NPE; p++)
        begin
            conv_sum = conv_sum + pe_sum[p];
        end
    end

    // relu folds into the max, base never below zero
    assign max_base = i_pos.first ? acc_t'(0) : max_q;
    assign max_next = (conv_sum > max_base) ? conv_sum : max_base;

    always_ff @(posedge i_clk or negedge i_rst)
    begin
        if (!i_rst)
        begin
            max_q   <= '0;
            o_data  <= '0;
            o_valid <= 1'b0;
        end
        else
        begin
            o_valid <= i_conv && i_pos.last;
            if (i_conv)
            begin
                max_q <= max_next;
                if (i_pos.last)
                begin
                    o_data <= max_next[`CNN_OUT_SHIFT+7:`CNN_OUT_SHIFT];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: cnn_core.sv
`timescale 1ns/100ps
`default_nettype none

module cnn_core
    import cnn_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_rst,
    input  wire logic [15:0] i_data,
    input  wire logic        i_valid,
    output logic [7:0]       o_data,
    output logic             o_valid
);

    kern_wr_t  kern_wr;
    tile_wr_t  tile_wr;
    win_pos_t  pos;
    logic      conv;
    kern_arr_t kernels;
    tile_arr_t tile;

    load_ctrl u_load_ctrl (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_valid   (i_valid),
        .o_kern_wr (kern_wr),
        .o_tile_wr (tile_wr),
        .o_pos     (pos),
        .o_conv    (conv)
    );

    // weights use the low byte only
    kernel_buffer u_kernel_buffer (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_wr      (kern_wr),
        .i_data    (pixel_t'(i_data[7:0])),
        .o_kernels (kernels)
    );

    tile_buffer u_tile_buffer (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_wr      (tile_wr),
        .i_data    (i_data),
        .o_tile    (tile)
    );

    conv_pool u_conv_pool (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_kernels (kernels),
        .i_tile    (tile),
        .i_pos     (pos),
        .i_conv    (conv),
        .o_data    (o_data),
        .o_valid   (o_valid)
    );

endmodule

`default_nettype wire

// File: tb_cnn_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "cnn_settings.svh"

module tb_cnn_core
    import cnn_pkg::*;
();

    localparam int KSZ        = `CNN_KERNEL * `CNN_KERNEL;
    localparam int TSZ        = `CNN_TILE * `CNN_TILE;
    localparam int NSETS      = 3;
    localparam int NTILES     = NSETS * `CNN_TILES_PER_SET;
    localparam int KBEATS     = `CNN_CHANNELS * KSZ;
    localparam int TBEATS     = `CNN_CHANNELS * TSZ / 2;
    localparam int MAX_CYCLES = 3 * (KBEATS + `CNN_TILES_PER_SET * (TBEATS + 4)) * NSETS + 200;

    logic        i_clk;
    logic        i_rst;
    logic        i_valid;
    logic [15:0] i_data;
    logic [7:0]  o_data;
    logic        o_valid;

    pixel_t weights [KBEATS];
    pixel_t pixels [`CNN_CHANNELS*TSZ];     // channel, row, column
    integer seed;
    int     fd;
    int     cycles;
    int     pulses;

    cnn_core dut0 (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_data  (i_data),
        .i_valid (i_valid),
        .o_data  (o_data),
        .o_valid (o_valid)
    );

    always #2 i_clk = ~i_clk;

    always @(posedge i_clk)
    begin
        cycles++;
        if (cycles > MAX_CYCLES)
        begin
            stop_on_error($sformatf("timeout, tests not done after %0d cycles", MAX_CYCLES));
        end
    end

    always @(negedge i_clk)
    begin
        if (o_valid === 1'b1)
        begin
            pulses++;
        end
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_no_valid();
        assert (o_valid === 1'b0)
        else stop_on_error($sformatf("Fail o_valid: got %h expected %h", o_valid, 1'b0));
    endtask

    task automatic read_byte(output logic [7:0] b);
        int code;
        code = $fscanf(fd, "%h", b);
        if (code != 1)
        begin
            stop_on_error("pattern file ended early or holds a token that is not hex");
        end
    endtask

    // idle cycles ahead of some beats
    task automatic send_beat(input logic [15:0] d);
        int gap;
        gap = $random(seed) & 7;
        for (int g = 4; g < gap; g++)
        begin
            @(posedge i_clk);
            i_valid <= 1'b0;
            i_data  <= 16'($random(seed));
            @(negedge i_clk);
            check_no_valid();
        end
        @(posedge i_clk);
        i_valid <= 1'b1;
        i_data  <= d;
        @(negedge i_clk);
        check_no_valid();
    endtask

    task automatic send_kernels();
        for (int i = 0; i < KBEATS; i++)
        begin
            send_beat({8'($random(seed)), weights[i]});    // junk high byte
        end
    endtask

    task automatic send_tile();
        int base;
        for (int c = 0; c < `CNN_CHANNELS; c++)
        begin
            for (int k = 0; k < TSZ / 2; k++)
            begin
                // even row in the high byte, row below in the low byte
                base = c*TSZ + 2*(k/`CNN_TILE)*`CNN_TILE + k%`CNN_TILE;
                send_beat({pixels[base], pixels[base + `CNN_TILE]});
            end
        end
    endtask

    // relu and 2x2 max pool over the summed 3x3 convolutions
    function automatic logic [7:0] pooled_byte();
        int best;
        int sum;
        best = 0;
        for (int oy = 0; oy < 2; oy++)
        begin
            for (int ox = 0; ox < 2; ox++)
            begin
                sum = 0;
                for (int c = 0; c < `CNN_CHANNELS; c++)
                    for (int r = 0; r < `CNN_KERNEL; r++)
                        for (int k = 0; k < `CNN_KERNEL; k++)
                            sum += int'(pixels[c*TSZ + (r+oy)*`CNN_TILE + k + ox])
                                 * int'(weights[c*KSZ + r*`CNN_KERNEL + k]);
                if (sum > best)
                begin
                    best = sum;
                end
            end
        end
        return 8'(best >> `CNN_OUT_SHIFT);
    endfunction

    // hold puts junk beats on the bus while the core computes
    task automatic check_result(input bit hold, input logic [7:0] expected);
        int edges;
        edges = 0;
        do
        begin
            @(posedge i_clk);
            edges++;
            i_valid <= hold && (edges <= 4);
            i_data  <= 16'($random(seed));
            @(negedge i_clk);
        end
        while (o_valid !== 1'b1 && edges < 12);
        assert (o_valid === 1'b1)
        else stop_on_error("no o_valid pulse within 12 cycles after the last tile beat");
        assert (edges == 5)
        else stop_on_error($sformatf("Fail o_valid latency: got %h expected %h", edges, 5));
        assert (o_data === expected)
        else stop_on_error($sformatf("Fail o_data: got %h expected %h", o_data, expected));
    endtask

    initial
    begin
        logic [7:0]       b;
        logic [7:0]       file_byte;
        logic [7:0]       expected;
        logic [8*256-1:0] header;
        int               code;

        seed    = 43931;
        i_clk   = 1'b0;
        i_rst   = 1'b0;
        i_valid = 1'b0;
        i_data  = '0;
        fd = $fopen("cnn_patterns.hex", "r");
        if (fd == 0)
        begin
            stop_on_error("cannot open cnn_patterns.hex");
        end
        repeat (2)
        begin
            code = $fgets(header, fd);  // column description
            if (code == 0)
            begin
                stop_on_error("pattern file ends inside its header lines");
            end
        end
        repeat (8) @(posedge i_clk);
        i_rst <= 1'b1;
        for (int s = 0; s < NSETS; s++)
        begin
            for (int i = 0; i < KBEATS; i++)
            begin
                read_byte(b);
                weights[i] = b;
            end
            send_kernels();
            for (int t = 0; t < `CNN_TILES_PER_SET; t++)
            begin
                for (int i = 0; i < `CNN_CHANNELS*TSZ; i++)
                begin
                    read_byte(b);
                    pixels[i] = b;
                end
                read_byte(file_byte);
                expected = pooled_byte();
                if (expected != file_byte)
                begin
                    stop_on_error($sformatf("pattern file lists %h for set %0d tile %0d, %s %h",
                        file_byte, s, t, "but the convolution gives", expected));
                end
                send_tile();
                check_result((s + t) % 2 == 0, expected);
            end
        end
        $fclose(fd);
        repeat (4)
        begin
            @(posedge i_clk);
            i_valid <= 1'b0;
            @(negedge i_clk);
            check_no_valid();
        end
        assert (pulses == NTILES)
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
        else
        begin
            stop_on_error($sformatf("Fail o_valid pulses: got %h expected %h", pulses, NTILES));
        end
    end

endmodule

`default_nettype wire

// File: cnn_patterns.hex
# kernel line: 72 weights, channel then row then column; tile line: 128 pixels, same order
# result line: expected output byte; each kernel line is followed by two tile and result pairs
01 01 01 01 01 01 01 01 01 02 02 02 02 02 02 02 02 02 03 03 03 03 03 03 03 03 03 04 04 04 04 04 04 04 04 04 05 05 05 05 05 05 05 05 05 06 06 06 06 06 06 06 06 06 07 07 07 07 07 07 07 07 07 08 08 08 08 08 08 08 08 08
01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10
1b
fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe fe
00
00 ff 00 ff 08 fe 00 ff 00 00 ff 00 ff 08 fe 00 ff 00 00 ff 00 ff 08 fe 00 ff 00 00 ff 00 ff 08 fe 00 ff 00 00 ff 00 ff 08 fe 00 ff 00 00 ff 00 ff 08 fe 00 ff 00 00 ff 00 ff 08 fe 00 ff 00 00 ff 00 ff 08 fe 00 ff 00
00 00 00 00 00 00 7f 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 7f 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 7f 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 7f 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 7f 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 7f 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 7f 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 7f 00 00 00 00 00 00 00 00 00
3f
0f 0f 0f 0f 0f 0f 0f 0f 0f 0f 0f 0f 0f 0f 0f 0f 1e 1e 1e 1e 1e 1e 1e 1e 1e 1e 1e 1e 1e 1e 1e 1e 2d 2d 2d 2d 2d 2d 2d 2d 2d 2d 2d 2d 2d 2d 2d 2d 3c 3c 3c 3c 3c 3c 3c 3c 3c 3c 3c 3c 3c 3c 3c 3c 4b 4b 4b 4b 4b 4b 4b 4b 4b 4b 4b 4b 4b 4b 4b 4b 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 5a 69 69 69 69 69 69 69 69 69 69 69 69 69 69 69 69 78 78 78 78 78 78 78 78 78 78 78 78 78 78 78 78
0c
7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f
7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f
70
80 80 80 80 40 40 40 40 40 40 40 40 40 40 40 40 80 80 80 80 40 40 40 40 40 40 40 40 40 40 40 40 80 80 80 80 40 40 40 40 40 40 40 40 40 40 40 40 80 80 80 80 40 40 40 40 40 40 40 40 40 40 40 40 80 80 80 80 40 40 40 40 40 40 40 40 40 40 40 40 80 80 80 80 40 40 40 40 40 40 40 40 40 40 40 40 80 80 80 80 40 40 40 40 40 40 40 40 40 40 40 40 80 80 80 80 40 40 40 40 40 40 40 40 40 40 40 40
dc

// File: files.f
+incdir+.
cnn_pkg.sv
load_ctrl.sv
kernel_buffer.sv
tile_buffer.sv
pe_dot.sv
conv_pool.sv
cnn_core.sv
tb_cnn_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_cnn_core -f files.f
./obj_dir/Vtb_cnn_core > sim.log 2>&1 || true
cat sim.log
if grep -q "ALL TESTS PASSED" sim.log
then
    exit 0
fi
exit 1
